// ==== rtl/rx_defines.svh ====
// receiver sample packer defines
// channel count, buffer geometry and command bit positions in op

`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

////////////////////////////////////////
// audio channels
////////////////////////////////////////

`define RX_CHANS		4		// DDC audio channels feeding the packer
`define RX_CHAN_BITS	2		// log2(RX_CHANS)

////////////////////////////////////////
// shared sample buffer
////////////////////////////////////////

`define RXBUF_DEPTH		1024	// 16-bit words, pointers just wrap
`define RXBUF_ADDR_BITS	10		// log2(RXBUF_DEPTH)

////////////////////////////////////////
// one-hot op bits
////////////////////////////////////////

`define OP_SET_RX_NSAMPS	0	// wr_reg: samples per block from tos
`define OP_GET_RX_SAMP		1	// wr_evt: read next buffer word
`define OP_GET_BUF_CTR		2	// wr_evt: read block counter
`define OP_GET_RX_SRQ		3	// rd_reg: poll and clear service request

`endif

// ==== rtl/rx_pkg.sv ====
// receiver sample packer types
// word widths and the sequencer state/source encodings

`default_nettype none

`include "rx_defines.svh"

package rx_pkg;

	typedef logic [15:0]					sample_word_t;	// one buffer word
	typedef logic [47:0]					ticks_t;		// timestamp
	typedef logic [7:0]						nsamps_t;		// audio samples per block
	typedef logic [31:0]					tos_t;			// cpu top of stack
	typedef logic [15:0]					op_t;			// one-hot opcode field
	typedef logic [`RXBUF_ADDR_BITS-1:0]	buf_addr_t;
	typedef logic [`RX_CHAN_BITS-1:0]		rx_chan_t;

	// block transfer sequencer
	typedef enum logic [2:0] {
		IDLE,			// waiting for rx_avail
		CHAN_MOVE,		// i, q, iq3 per channel
		BLOCK_CHECK,	// decide stop or close block
		TICKS_MOVE,		// 3 timestamp words
		CTR_MOVE		// block counter word
	} xfer_state_t;

	// which word goes into the buffer on a write
	typedef enum logic [2:0] {
		WORD_I, WORD_Q, WORD_IQ3,
		WORD_TICKS_LO, WORD_TICKS_MID, WORD_TICKS_HI,
		WORD_CTR
	} word_sel_t;

endpackage

`default_nettype wire

// ==== rtl/rx_cmd_decode.sv ====
// receiver command decode
// qualifies cpu strobes with their op bits, holds the samples-per-block
// register and the service-request latch

`default_nettype none

`include "rx_defines.svh"

module rx_cmd_decode (
	input  wire					adc_clk,
	input  wire					reset_bufs_A,

	input  wire rx_pkg::op_t	op_i,		// one-hot opcode
	input  wire rx_pkg::tos_t	tos_i,		// operand
	input  wire					wr_reg_i,
	input  wire					wr_evt_i,
	input  wire					rd_reg_i,

	input  wire					block_done_i,	// from sequencer, one cycle

	output rx_pkg::nsamps_t		nrx_samps_o,
	output logic				get_samp_o,
	output logic				get_ctr_o,
	output logic				ser_o			// service request to cpu
	);

	import rx_pkg::*;

	////////////////////////////////////////
	// strobe qualify
	////////////////////////////////////////

	logic set_nsamps;		// load nrx_samps from tos
	logic get_srq;			// poll srq
	logic srq_noted;		// block closed since last poll

	assign set_nsamps = wr_reg_i && op_i[`OP_SET_RX_NSAMPS];
	assign get_samp_o = wr_evt_i && op_i[`OP_GET_RX_SAMP];	// combinational, same cycle
	assign get_ctr_o  = wr_evt_i && op_i[`OP_GET_BUF_CTR];
	assign get_srq    = rd_reg_i && op_i[`OP_GET_RX_SRQ];

	// samples per block
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			nrx_samps_o <= '0;
		else if (set_nsamps)
			nrx_samps_o <= tos_i[$bits(nsamps_t)-1:0];	// low byte of tos
	end

	////////////////////////////////////////
	// service request latch
	////////////////////////////////////////

	// noted collects block_done pulses, out is what the last poll saw
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			srq_noted <= 1'b0;
			ser_o     <= 1'b0;
		end
		else if (get_srq)
		begin
			srq_noted <= block_done_i;		// clear, unless a block closes right now
			ser_o     <= srq_noted;
		end
		else
			srq_noted <= srq_noted | block_done_i;
	end

	// the cpu only ever raises one op bit per strobe
	a_op_onehot: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		(wr_reg_i || wr_evt_i || rd_reg_i) |-> $onehot(op_i))
		else $error("op_i not one-hot with a strobe");

endmodule

`default_nettype wire

// ==== rtl/rx_xfer_sequencer.sv ====
// receiver block transfer sequencer
// on each rx_avail moves i, q, iq3 of every channel into the buffer, and on
// the last sample of a block appends the timestamp and the block counter

`default_nettype none

`include "rx_defines.svh"

module rx_xfer_sequencer (
	input  wire						adc_clk,
	input  wire						reset_bufs_A,

	input  wire						rx_avail_i,		// all channels ready, one cycle
	input  wire rx_pkg::nsamps_t	nrx_samps_i,	// samples per block

	output logic					wr_o,			// buffer write this cycle
	output rx_pkg::word_sel_t		word_sel_o,		// write source
	output rx_pkg::rx_chan_t		chan_o,			// channel for WORD_I/Q/IQ3
	output logic					block_done_o	// block closed, one cycle
	);

	import rx_pkg::*;

	xfer_state_t	state;
	nsamps_t		count;		// samples moved in the current block

	logic last_chan;			// on the final channel of the transfer
	logic last_samp;			// this transfer closes the block

	assign last_chan = (chan_o == rx_chan_t'(`RX_CHANS - 1));
	assign last_samp = (count == nrx_samps_i - 8'd1);

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	//  cycle:  A   1 .. 3*RX_CHANS   C   T T T  K   D
	//  A: rx_avail_i, C: BLOCK_CHECK, T: ticks lo/mid/hi
	//  K: counter word, D: block_done (back in IDLE)
	//  non-closing transfers stop at C

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			state        <= IDLE;
			count        <= '0;
			wr_o         <= 1'b0;
			word_sel_o   <= WORD_I;
			chan_o       <= '0;
			block_done_o <= 1'b0;
		end
		else
		begin
			block_done_o <= 1'b0;		// pulse only

			case (state)
				IDLE:
					if (rx_avail_i)
					begin
						state      <= CHAN_MOVE;
						wr_o       <= 1'b1;		// first write next cycle
						word_sel_o <= WORD_I;
						chan_o     <= '0;
					end

				CHAN_MOVE:
					case (word_sel_o)
						WORD_I:		word_sel_o <= WORD_Q;
						WORD_Q:		word_sel_o <= WORD_IQ3;
						default:	// iq3 done, next channel or stop writing
						begin
							word_sel_o <= WORD_I;
							if (last_chan)
							begin
								state <= BLOCK_CHECK;
								wr_o  <= 1'b0;
							end
							else
								chan_o <= chan_o + 1'b1;
						end
					endcase

				BLOCK_CHECK:
					if (last_samp)
					begin
						state      <= TICKS_MOVE;	// keep going, close the block
						wr_o       <= 1'b1;
						word_sel_o <= WORD_TICKS_LO;
					end
					else
					begin
						state <= IDLE;
						count <= count + 1'b1;
					end

				TICKS_MOVE:
					case (word_sel_o)
						WORD_TICKS_LO:	word_sel_o <= WORD_TICKS_MID;
						WORD_TICKS_MID:	word_sel_o <= WORD_TICKS_HI;
						default:
						begin
							state      <= CTR_MOVE;		// single counter word follows
							word_sel_o <= WORD_CTR;
						end
					endcase

				CTR_MOVE:
				begin
					state        <= IDLE;
					wr_o         <= 1'b0;
					word_sel_o   <= WORD_I;
					count        <= '0;
					block_done_o <= 1'b1;		// bumps block counter and srq
				end

				default:
				begin
					state <= IDLE;
					wr_o  <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// channels must not deliver faster than a full block-closing transfer
	a_avail_gap: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		rx_avail_i |=> (!rx_avail_i) [*(3*`RX_CHANS + 7)])
		else $error("rx_avail_i too soon after previous pulse");

	a_avail_idle: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		rx_avail_i |-> (state == IDLE))
		else $error("rx_avail_i during a transfer");

	a_wr_idle: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		(state == IDLE) |-> !wr_o)
		else $error("buffer write while idle");

endmodule

`default_nettype wire

// ==== rtl/rx_sample_buffer.sv ====
// receiver shared sample buffer
// write-word mux, ticks latch, block counter, wrapping pointers,
// inferred dual-port memory and the registered cpu readout

`default_nettype none

`include "rx_defines.svh"

module rx_sample_buffer (
	input  wire							adc_clk,
	input  wire							reset_bufs_A,

	input  wire							rx_avail_i,
	// word 3*ch+0 = i, 3*ch+1 = q, 3*ch+2 = iq3, held until next rx_avail
	input  wire rx_pkg::sample_word_t [3*`RX_CHANS-1:0]	rxn_words_i,
	input  wire rx_pkg::ticks_t			ticks_i,

	input  wire							wr_i,
	input  wire rx_pkg::word_sel_t		word_sel_i,
	input  wire rx_pkg::rx_chan_t		chan_i,
	input  wire							block_done_i,

	input  wire							get_samp_i,	// read next word
	input  wire							get_ctr_i,	// read block counter

	output logic						rx_rd_o,	// one cycle after command
	output rx_pkg::sample_word_t		rx_dout_o
	);

	import rx_pkg::*;

	ticks_t			ticks_lat;		// timestamp of the current transfer
	sample_word_t	buf_ctr;		// closed blocks
	sample_word_t	din;
	buf_addr_t		waddr, raddr;

	logic [`RX_CHAN_BITS+1:0]	word_base;	// 3*chan_i, first word of the channel

	sample_word_t	mem [`RXBUF_DEPTH];
	sample_word_t	ram_q;
	sample_word_t	ctr_q;
	logic			sel_ctr_q;

	////////////////////////////////////////
	// write side
	////////////////////////////////////////

	always_ff @(posedge adc_clk)
		if (rx_avail_i)
			ticks_lat <= ticks_i;

	assign word_base = ({2'b00, chan_i} << 1) + {2'b00, chan_i};

	always_comb
	begin
		case (word_sel_i)
			WORD_I:			din = rxn_words_i[word_base];
			WORD_Q:			din = rxn_words_i[word_base + 1'b1];
			WORD_IQ3:		din = rxn_words_i[word_base + 2'd2];
			WORD_TICKS_LO:	din = ticks_lat[15:0];
			WORD_TICKS_MID:	din = ticks_lat[31:16];
			WORD_TICKS_HI:	din = ticks_lat[47:32];
			WORD_CTR:		din = buf_ctr;		// value before this block's increment
			default:		din = '0;
		endcase
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			buf_ctr <= '0;
			waddr   <= '0;
			raddr   <= '0;
		end
		else
		begin
			buf_ctr <= buf_ctr + block_done_i;
			waddr   <= waddr + wr_i;		// wraps at RXBUF_DEPTH
			raddr   <= raddr + get_samp_i;
		end
	end

	always_ff @(posedge adc_clk)
		if (wr_i)
			mem[waddr] <= din;

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	always_ff @(posedge adc_clk)
		if (get_samp_i)
			ram_q <= mem[raddr];		// reader must stay ahead of the wrap

	always_ff @(posedge adc_clk)
	begin
		ctr_q     <= buf_ctr;
		sel_ctr_q <= get_ctr_i;
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			rx_rd_o <= 1'b0;
		else
			rx_rd_o <= get_samp_i | get_ctr_i;
	end

	assign rx_dout_o = sel_ctr_q ? ctr_q : ram_q;

endmodule

`default_nettype wire

// ==== rtl/rx_receiver_top.sv ====
// receiver sample packer top level
// command decode, transfer sequencer and shared sample buffer

`default_nettype none

`include "rx_defines.svh"

module rx_receiver_top (
	input  wire							adc_clk,
	input  wire							reset_bufs_A,

	// embedded cpu
	input  wire rx_pkg::op_t			op_i,
	input  wire rx_pkg::tos_t			tos_i,
	input  wire							wr_reg_i,
	input  wire							wr_evt_i,
	input  wire							rd_reg_i,
	output logic						ser_o,

	// channel side
	input  wire							rx_avail_i,
	input  wire rx_pkg::sample_word_t [3*`RX_CHANS-1:0]	rxn_words_i,
	input  wire rx_pkg::ticks_t			ticks_i,

	// readout
	output logic						rx_rd_o,
	output rx_pkg::sample_word_t		rx_dout_o
	);

	import rx_pkg::*;

	nsamps_t	nrx_samps;
	logic		get_samp, get_ctr;
	logic		wr, block_done;
	word_sel_t	word_sel;
	rx_chan_t	chan;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	rx_cmd_decode u_decode (
		.adc_clk		(adc_clk),
		.reset_bufs_A	(reset_bufs_A),
		.op_i			(op_i),
		.tos_i			(tos_i),
		.wr_reg_i		(wr_reg_i),
		.wr_evt_i		(wr_evt_i),
		.rd_reg_i		(rd_reg_i),
		.block_done_i	(block_done),
		.nrx_samps_o	(nrx_samps),
		.get_samp_o		(get_samp),
		.get_ctr_o		(get_ctr),
		.ser_o			(ser_o)
	);

	////////////////////////////////////////
	// transfer sequencing
	////////////////////////////////////////

	rx_xfer_sequencer u_seq (
		.adc_clk		(adc_clk),
		.reset_bufs_A	(reset_bufs_A),
		.rx_avail_i		(rx_avail_i),
		.nrx_samps_i	(nrx_samps),
		.wr_o			(wr),
		.word_sel_o		(word_sel),
		.chan_o			(chan),
		.block_done_o	(block_done)
	);

	////////////////////////////////////////
	// buffer and readout
	////////////////////////////////////////

	rx_sample_buffer u_buffer (
		.adc_clk		(adc_clk),
		.reset_bufs_A	(reset_bufs_A),
		.rx_avail_i		(rx_avail_i),
		.rxn_words_i	(rxn_words_i),
		.ticks_i		(ticks_i),
		.wr_i			(wr),
		.word_sel_i		(word_sel),
		.chan_i			(chan),
		.block_done_i	(block_done),
		.get_samp_i		(get_samp),
		.get_ctr_i		(get_ctr),
		.rx_rd_o		(rx_rd_o),
		.rx_dout_o		(rx_dout_o)
	);

endmodule

`default_nettype wire

// ==== test/tb_rx_receiver.sv ====
// receiver sample packer testbench
// directed tests through the cpu strobes, with a channel model and a
// reference queue of the expected buffer word stream

`default_nettype none

`include "rx_defines.svh"

module tb_rx_receiver;

	timeunit 1ns;
	timeprecision 100ps;

	import rx_pkg::*;

	localparam int N_WORDS      = 3*`RX_CHANS;		// channel words per transfer
	localparam int AVAIL_GAP    = 3*`RX_CHANS + 8;	// min rx_avail spacing
	localparam int IDLE_TIMEOUT = 200;

	logic							adc_clk;
	logic							reset_bufs_A;
	op_t							op_i;
	tos_t							tos_i;
	logic							wr_reg_i, wr_evt_i, rd_reg_i;
	logic							ser_o;
	logic							rx_avail_i;
	sample_word_t [N_WORDS-1:0]		rxn_words_i;
	ticks_t							ticks_i;
	logic							rx_rd_o;
	sample_word_t					rx_dout_o;

	// reference model
	sample_word_t	exp_q[$];		// words in buffer order that are not yet read
	int				samp_cnt;		// samples in the open block
	int				blk_ctr;		// closed blocks
	int				nsamps;			// samples per block as programmed

	rx_receiver_top uut (
		.adc_clk		(adc_clk),
		.reset_bufs_A	(reset_bufs_A),
		.op_i			(op_i),
		.tos_i			(tos_i),
		.wr_reg_i		(wr_reg_i),
		.wr_evt_i		(wr_evt_i),
		.rd_reg_i		(rd_reg_i),
		.ser_o			(ser_o),
		.rx_avail_i		(rx_avail_i),
		.rxn_words_i	(rxn_words_i),
		.ticks_i		(ticks_i),
		.rx_rd_o		(rx_rd_o),
		.rx_dout_o		(rx_dout_o)
	);

	initial
	begin
		adc_clk = 1'b0;
		forever #50 adc_clk = ~adc_clk;		// 100 ns
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task check_eq(input logic [47:0] got, input logic [47:0] exp, input string what);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// drives a one-cycle cpu strobe and returns mid-cycle after the next edge
	task cpu_strobe(input int op_bit, input logic reg_wr, input logic evt, input logic rd,
			input tos_t tos);
		@(posedge adc_clk);
		op_i     <= op_t'(1) << op_bit;
		tos_i    <= tos;
		wr_reg_i <= reg_wr;
		wr_evt_i <= evt;
		rd_reg_i <= rd;
		@(negedge adc_clk);
		check_eq(rx_rd_o, 1'b0, "rx_rd_o high in the strobe cycle");
		@(posedge adc_clk);
		op_i     <= '0;
		wr_reg_i <= 1'b0;
		wr_evt_i <= 1'b0;
		rd_reg_i <= 1'b0;
		@(negedge adc_clk);		// outputs settled
	endtask

	task set_nsamps(input int n);
		cpu_strobe(`OP_SET_RX_NSAMPS, 1'b1, 1'b0, 1'b0, tos_t'(n));
		nsamps = n;
	endtask

	task poll_srq(input logic exp);
		cpu_strobe(`OP_GET_RX_SRQ, 1'b0, 1'b0, 1'b1, '0);
		check_eq(ser_o, exp, "ser_o after srq poll");
		check_eq(rx_rd_o, 1'b0, "rx_rd_o on srq poll");
	endtask

	task read_ctr(input int exp);
		cpu_strobe(`OP_GET_BUF_CTR, 1'b0, 1'b1, 1'b0, '0);
		check_eq(rx_rd_o, 1'b1, "rx_rd_o one cycle after counter read");
		check_eq(rx_dout_o, exp, "block counter read");
	endtask

	task read_sample();
		sample_word_t exp;
		if (exp_q.size() == 0)
		begin
			$display("sample read with no word left in the reference stream");
			$display("RESULT: FAIL");
			$fatal(1, "reference stream empty");
		end
		else
		begin
			exp = exp_q.pop_front();
			cpu_strobe(`OP_GET_RX_SAMP, 1'b0, 1'b1, 1'b0, '0);
			check_eq(rx_rd_o, 1'b1, "rx_rd_o one cycle after sample read");
			check_eq(rx_dout_o, exp, "buffer word");
		end
	endtask

	// bounded wait that keeps the rx_avail spacing and lets the transfer end
	task wait_idle();
		int n;
		n = 0;
		while (n < AVAIL_GAP || uut.u_seq.state != IDLE)
		begin
			@(negedge adc_clk);
			n++;
			if (n > IDLE_TIMEOUT)
			begin
				$display("timeout, sequencer did not return to idle after rx_avail");
				$display("RESULT: FAIL");
				$fatal(1, "sequencer stalled");
			end
		end
	endtask

	// channel model for one audio sample on every channel
	task send_sample();
		sample_word_t [N_WORDS-1:0]	words;
		logic [63:0]				rnd;
		ticks_t						ts;
		int							k;
		for (k = 0; k < N_WORDS; k++)
			words[k] = sample_word_t'($urandom());
		rnd = {$urandom(), $urandom()};
		ts  = rnd[47:0];
		for (k = 0; k < N_WORDS; k++)
			exp_q.push_back(words[k]);		// ch0 i q iq3 then ch1 ...
		if (samp_cnt == nsamps - 1)
		begin
			exp_q.push_back(ts[15:0]);
			exp_q.push_back(ts[31:16]);
			exp_q.push_back(ts[47:32]);
			exp_q.push_back(sample_word_t'(blk_ctr));	// counter before increment
			blk_ctr++;
			samp_cnt = 0;
		end
		else
			samp_cnt++;
		@(posedge adc_clk);
		rxn_words_i <= words;
		ticks_i     <= ts;
		rx_avail_i  <= 1'b1;
		@(posedge adc_clk);
		rx_avail_i  <= 1'b0;
		wait_idle();
	endtask

	task apply_reset();
		@(posedge adc_clk);
		reset_bufs_A <= 1'b1;
		repeat (8) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		exp_q.delete();
		samp_cnt = 0;
		blk_ctr  = 0;
		nsamps   = 0;
		@(negedge adc_clk);
		check_eq(ser_o, 1'b0, "ser_o after reset");
	endtask

	////////////////////////////////////////
	// directed sequence
	////////////////////////////////////////

	initial
	begin
		void'($urandom(32'hb628));
		reset_bufs_A = 1'b1;
		op_i         = '0;
		tos_i        = '0;
		wr_reg_i     = 1'b0;
		wr_evt_i     = 1'b0;
		rd_reg_i     = 1'b0;
		rx_avail_i   = 1'b0;
		rxn_words_i  = '0;
		ticks_i      = '0;
		samp_cnt     = 0;
		blk_ctr      = 0;
		nsamps       = 0;
		repeat (8) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;

		poll_srq(1'b0);			// nothing closed yet
		read_ctr(0);

		set_nsamps(2);			// one block of two samples
		repeat (2) send_sample();
		repeat (2*N_WORDS + 4) read_sample();

		poll_srq(1'b1);
		poll_srq(1'b0);			// poll clears the latch
		read_ctr(1);

		set_nsamps(3);			// three blocks with counter words 1..3
		repeat (9) send_sample();
		repeat (3*(3*N_WORDS + 4)) read_sample();
		poll_srq(1'b1);			// blocks closed since the last poll

		send_sample();			// part of a block that is partly read
		repeat (5) read_sample();
		apply_reset();

		set_nsamps(2);			// back from address 0 with counter word 0
		repeat (2) send_sample();
		repeat (2*N_WORDS + 4) read_sample();
		read_ctr(1);
		poll_srq(1'b1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/rx_pkg.sv
rtl/rx_cmd_decode.sv
rtl/rx_xfer_sequencer.sv
rtl/rx_sample_buffer.sv
rtl/rx_receiver_top.sv
test/tb_rx_receiver.sv

// ==== Bender.yml ====
package:
  name: rx_receiver

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rx_pkg.sv
      - rtl/rx_cmd_decode.sv
      - rtl/rx_xfer_sequencer.sv
      - rtl/rx_sample_buffer.sv
      - rtl/rx_receiver_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_rx_receiver.sv
